// ==== files.f ====
hw/rp_pkg.sv
hw/adc_frontend.sv
hw/norm_diff_ctrl.sv
hw/serial_divider.sv
hw/dac_output.sv
hw/led_blinker.sv
hw/rp_norm_top.sv
tb/tb_checker.sv
tb/tb_rp_norm_assertions.sv
tb/tb_rp_norm.sv

// ==== hw/adc_frontend.sv ====
// adc front end
// registers both raw adc words, turns negative-slope offset code
// into two's complement

`timescale 1ns/1ps

module adc_frontend (
  input  logic                              adc_clk,
  input  logic                              rst_n_i,
  input  logic        [rp_pkg::ADC_W-1:0]   adc_a_raw_i,  // raw, neg-slope
  input  logic        [rp_pkg::ADC_W-1:0]   adc_b_raw_i,
  output logic signed [rp_pkg::ADC_W-1:0]   adc_a_o,      // two's complement
  output logic signed [rp_pkg::ADC_W-1:0]   adc_b_o
);

  // keep msb, flip the rest
  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      adc_a_o <= '0;
      adc_b_o <= '0;
    end else begin
      adc_a_o <= {adc_a_raw_i[rp_pkg::ADC_W-1], ~adc_a_raw_i[rp_pkg::ADC_W-2:0]};
      adc_b_o <= {adc_b_raw_i[rp_pkg::ADC_W-1], ~adc_b_raw_i[rp_pkg::ADC_W-2:0]};
    end
  end

endmodule

// ==== hw/dac_output.sv ====
// dac output stage
// holds the dac codes in inverted neg-slope form, marks each
// update and drives the dac reset pin

`timescale 1ns/1ps

module dac_output (
  input  logic                              adc_clk,
  input  logic                              rst_n_i,
  input  logic signed [rp_pkg::ADC_W-1:0]   sum_i,
  input  logic signed [rp_pkg::ADC_W-1:0]   ratio_i,
  input  logic                              upd_i,
  output logic        [rp_pkg::ADC_W-1:0]   dac_a_o,     // sum
  output logic        [rp_pkg::ADC_W-1:0]   dac_b_o,     // ratio
  output logic                              dac_upd_o,
  output logic                              dac_reset_o
);

  // dac codes, all ones is 0
  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dac_a_o   <= '1;
      dac_b_o   <= '1;
      dac_upd_o <= 1'b0;
    end else begin
      dac_upd_o <= upd_i;
      if (upd_i) begin
        dac_a_o <= ~sum_i;    // two's complement to neg-slope
        dac_b_o <= ~ratio_i;
      end
    end
  end

  // dac held in reset until the first edge after release
  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i)
      dac_reset_o <= 1'b1;
    else
      dac_reset_o <= 1'b0;
  end

endmodule

// ==== hw/led_blinker.sv ====
// led blinker
// toggles the led every half_period clock cycles

`timescale 1ns/1ps

module led_blinker #(
  parameter logic [rp_pkg::LED_CNT_W-1:0] half_period = rp_pkg::LED_HALF_PERIOD_DEF
) (
  input  logic adc_clk,
  input  logic rst_n_i,
  output logic led_o
);

  logic [rp_pkg::LED_CNT_W-1:0] cnt;  // cycles into the current half period

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt   <= '0;
      led_o <= 1'b0;
    end else if (cnt == half_period - 1'b1) begin
      cnt   <= '0;      // restart
      led_o <= ~led_o;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

// ==== hw/norm_diff_ctrl.sv ====
// normalized difference controller
// registers a+b and a-b, hands |diff|<<12 / |sum| to the serial
// divider over req/ack, then signs and clamps sum and ratio to 14 bits

`timescale 1ns/1ps

module norm_diff_ctrl (
  input  logic                                  adc_clk,
  input  logic                                  rst_n_i,
  input  logic signed [rp_pkg::ADC_W-1:0]       adc_a_i,
  input  logic signed [rp_pkg::ADC_W-1:0]       adc_b_i,
  output logic                                  div_req_o,
  output logic        [rp_pkg::DIVIDEND_W-1:0]  div_dividend_o,  // |diff| << FRAC_W
  output logic        [rp_pkg::SUM_W-1:0]       div_divisor_o,   // |sum|, never 0
  input  logic                                  div_ack_i,
  input  logic        [rp_pkg::DIVIDEND_W-1:0]  div_quot_i,
  output logic signed [rp_pkg::ADC_W-1:0]       sum_o,
  output logic signed [rp_pkg::ADC_W-1:0]       ratio_o,
  output logic                                  upd_o            // one cycle strobe
);

  logic signed [rp_pkg::SUM_W-1:0] sum_r;     // a+b
  logic signed [rp_pkg::SUM_W-1:0] diff_r;    // a-b
  logic        [rp_pkg::SUM_W-1:0] sum_mag;
  logic        [rp_pkg::SUM_W-1:0] diff_mag;
  logic                            res_neg;   // ratio sign, kept while divider runs
  logic                            idle;

  // clamp 15 bit sum into dac range
  function automatic logic signed [rp_pkg::ADC_W-1:0] sat_sum(
    input logic signed [rp_pkg::SUM_W-1:0] s
  );
    if (s > rp_pkg::DAC_MAX)
      return rp_pkg::ADC_W'(rp_pkg::DAC_MAX);
    if (s < rp_pkg::DAC_MIN)
      return rp_pkg::ADC_W'(rp_pkg::DAC_MIN);
    return s[rp_pkg::ADC_W-1:0];
  endfunction

  assign sum_mag  = sum_r[rp_pkg::SUM_W-1]  ? rp_pkg::SUM_W'(-sum_r)  : sum_r;
  assign diff_mag = diff_r[rp_pkg::SUM_W-1] ? rp_pkg::SUM_W'(-diff_r) : diff_r;

  // no open handshake and no strobe this cycle
  assign idle = !div_req_o && !div_ack_i && !upd_o;

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sum_r          <= '0;
      diff_r         <= '0;
      div_req_o      <= 1'b0;
      div_dividend_o <= '0;
      div_divisor_o  <= '0;
      res_neg        <= 1'b0;
      sum_o          <= '0;
      ratio_o        <= '0;
      upd_o          <= 1'b0;
    end else begin
      sum_r  <= adc_a_i + adc_b_i;  // free running
      diff_r <= adc_a_i - adc_b_i;
      upd_o  <= 1'b0;
      if (idle) begin
        sum_o <= sat_sum(sum_r);
        if (sum_r == '0) begin
          ratio_o <= '0;  // no division by zero, answer directly
          upd_o   <= 1'b1;
        end else begin
          div_dividend_o <= {diff_mag, {rp_pkg::FRAC_W{1'b0}}};
          div_divisor_o  <= sum_mag;
          res_neg        <= sum_r[rp_pkg::SUM_W-1] ^ diff_r[rp_pkg::SUM_W-1];
          div_req_o      <= 1'b1;
        end
      end else if (div_req_o && div_ack_i) begin
        div_req_o <= 1'b0;  // quotient taken, release
        upd_o     <= 1'b1;
        if (!res_neg)
          ratio_o <= (div_quot_i > rp_pkg::DAC_MAX) ? rp_pkg::ADC_W'(rp_pkg::DAC_MAX)
                                                    : div_quot_i[rp_pkg::ADC_W-1:0];
        else
          ratio_o <= (div_quot_i > -rp_pkg::DAC_MIN) ? rp_pkg::ADC_W'(rp_pkg::DAC_MIN)
                                                     : rp_pkg::ADC_W'(-div_quot_i);
      end
    end
  end

endmodule

// ==== hw/rp_norm_top.sv ====
// normalized difference top level
// adc a/b in, dac a gets a+b, dac b gets (a-b)/(a+b) in 1.12,
// plus dac reset and a blinking led

`timescale 1ns/1ps

module rp_norm_top #(
  parameter logic [rp_pkg::LED_CNT_W-1:0] led_half_period = rp_pkg::LED_HALF_PERIOD_DEF
) (
  input  logic                        adc_clk,
  input  logic                        rst_n_i,
  input  logic [rp_pkg::ADC_W-1:0]    adc_a_raw_i,
  input  logic [rp_pkg::ADC_W-1:0]    adc_b_raw_i,
  output logic [rp_pkg::ADC_W-1:0]    dac_a_o,      // sum
  output logic [rp_pkg::ADC_W-1:0]    dac_b_o,      // normalized difference
  output logic                        dac_upd_o,
  output logic                        dac_reset_o,
  output logic                        led_o
);

  //////////////////////////////
  // local signals
  //////////////////////////////

  logic signed [rp_pkg::ADC_W-1:0]      adc_a;
  logic signed [rp_pkg::ADC_W-1:0]      adc_b;
  logic                                 div_req;
  logic        [rp_pkg::DIVIDEND_W-1:0] div_dividend;
  logic        [rp_pkg::SUM_W-1:0]      div_divisor;
  logic                                 div_ack;
  logic        [rp_pkg::DIVIDEND_W-1:0] div_quot;
  logic signed [rp_pkg::ADC_W-1:0]      sum_sat;
  logic signed [rp_pkg::ADC_W-1:0]      ratio_sat;
  logic                                 upd;

  //////////////////////////////
  // signal path
  //////////////////////////////

  adc_frontend i_adc_frontend (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .adc_a_raw_i (adc_a_raw_i),
    .adc_b_raw_i (adc_b_raw_i),
    .adc_a_o     (adc_a),
    .adc_b_o     (adc_b)
  );

  norm_diff_ctrl i_norm_diff_ctrl (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .adc_a_i        (adc_a),
    .adc_b_i        (adc_b),
    .div_req_o      (div_req),       // requester side
    .div_dividend_o (div_dividend),
    .div_divisor_o  (div_divisor),
    .div_ack_i      (div_ack),
    .div_quot_i     (div_quot),
    .sum_o          (sum_sat),
    .ratio_o        (ratio_sat),
    .upd_o          (upd)
  );

  serial_divider i_serial_divider (
    .adc_clk    (adc_clk),
    .rst_n_i    (rst_n_i),
    .req_i      (div_req),
    .dividend_i (div_dividend),
    .divisor_i  (div_divisor),
    .ack_o      (div_ack),
    .quot_o     (div_quot)
  );

  dac_output i_dac_output (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .sum_i       (sum_sat),          // swapped as on the board, sum on dac a
    .ratio_i     (ratio_sat),
    .upd_i       (upd),
    .dac_a_o     (dac_a_o),
    .dac_b_o     (dac_b_o),
    .dac_upd_o   (dac_upd_o),
    .dac_reset_o (dac_reset_o)
  );

  // heartbeat
  led_blinker #(
    .half_period (led_half_period)
  ) i_led_blinker (
    .adc_clk (adc_clk),
    .rst_n_i (rst_n_i),
    .led_o   (led_o)
  );

endmodule

// ==== hw/rp_pkg.sv ====
// shared widths and constants of the normalized difference path
// adc sample width, sum and ratio formats, dac limits, led timing

package rp_pkg;

  //////////////////////////////
  // data path widths
  //////////////////////////////

  localparam int ADC_W  = 14;  // adc sample and dac code
  localparam int SUM_W  = 15;  // a+b and a-b without overflow
  localparam int FRAC_W = 12;  // ratio fraction bits, 1.0 -> 4096

  // |diff| shifted up by the fraction bits
  localparam int DIVIDEND_W = SUM_W + FRAC_W;

  // divider step counter, counts 0 .. DIVIDEND_W-1
  localparam int STEP_W = $clog2(DIVIDEND_W);

  //////////////////////////////
  // dac range
  //////////////////////////////

  localparam int DAC_MAX =  8191;  // largest signed code
  localparam int DAC_MIN = -8192;  // smallest signed code

  //////////////////////////////
  // led
  //////////////////////////////

  localparam int LED_CNT_W = 28;

  // about 1 s per half period at 125 MHz
  localparam logic [LED_CNT_W-1:0] LED_HALF_PERIOD_DEF = 28'd125_000_000;

endpackage

// ==== hw/serial_divider.sv ====
// serial divider
// restoring shift-subtract, one quotient bit per clock,
// acknowledging side of the four-phase req/ack handshake

`timescale 1ns/1ps

module serial_divider (
  input  logic                                adc_clk,
  input  logic                                rst_n_i,
  input  logic                                req_i,
  input  logic [rp_pkg::DIVIDEND_W-1:0]       dividend_i,
  input  logic [rp_pkg::SUM_W-1:0]            divisor_i,   // held by requester
  output logic                                ack_o,
  output logic [rp_pkg::DIVIDEND_W-1:0]       quot_o
);

  logic [rp_pkg::SUM_W-1:0]       rem_r;     // partial remainder
  logic [rp_pkg::DIVIDEND_W-1:0]  quot_r;    // dividend out at top, quotient in at bottom
  logic [rp_pkg::STEP_W-1:0]      step_cnt;
  logic                           busy;
  logic                           start;
  logic [rp_pkg::SUM_W:0]         trial;     // remainder with next dividend bit
  logic [rp_pkg::SUM_W:0]         trial_sub;
  logic                           fits;      // divisor goes in, quotient bit 1

  //////////////////////////////
  // step logic
  //////////////////////////////

  assign trial     = {rem_r, quot_r[rp_pkg::DIVIDEND_W-1]};
  assign trial_sub = trial - {1'b0, divisor_i};
  assign fits      = trial >= {1'b0, divisor_i};

  // accept only a fresh request
  assign start = req_i && !busy && !ack_o;

  assign quot_o = quot_r;

  // datapath
  always_ff @(posedge adc_clk) begin
    if (start) begin
      rem_r  <= '0;
      quot_r <= dividend_i;
    end else if (busy) begin
      // remainder stays below divisor, top bit is never needed
      rem_r  <= fits ? trial_sub[rp_pkg::SUM_W-1:0] : trial[rp_pkg::SUM_W-1:0];
      quot_r <= {quot_r[rp_pkg::DIVIDEND_W-2:0], fits};
    end
  end

  //////////////////////////////
  // handshake and step count
  //////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy     <= 1'b0;
      ack_o    <= 1'b0;
      step_cnt <= '0;
    end else begin
      if (start) begin
        busy     <= 1'b1;
        step_cnt <= '0;
      end else if (busy) begin
        step_cnt <= step_cnt + 1'b1;
        if (step_cnt == rp_pkg::STEP_W'(rp_pkg::DIVIDEND_W - 1)) begin
          busy  <= 1'b0;  // last bit lands with ack
          ack_o <= 1'b1;
        end
      end else if (ack_o && !req_i) begin
        ack_o <= 1'b0;    // requester let go
      end
    end
  end

endmodule

// ==== tb/norm_cases.txt ====
# name  raw_a  raw_b  dac_a  dac_b   (hex, raw in neg-slope code)
# dac codes are the inverse of the saturated sum and ratio
pos_small     1c17 1e0b 3a23 3aaa
neg_ratio     1f37 1da7 3cdf 07ff
neg_sum       212b 2063 018f 37ff
sat_sum       088f 0c77 2000 3e8b
sat_ratio_pos 1f9b 2031 3fcd 2000
sat_ratio_neg 2031 1f9b 3fcd 1fff
zero_sum      1d43 22bb 3fff 3fff
trunc_neg     1ffe 1ffd 3ffc 0554
sat_sum_neg   3f3f 3f3f 1fff 3fff

// ==== tb/tb_checker.sv ====
// result checker
// compares dac codes at the second update after each case starts,
// checks the reset state and the led rhythm, keeps the counts

`timescale 1ns/1ps

module tb_checker #(
  parameter int half_period = 8
) (
  input  logic                     adc_clk,
  input  logic                     rst_n_i,
  input  logic [rp_pkg::ADC_W-1:0] dac_a_i,
  input  logic [rp_pkg::ADC_W-1:0] dac_b_i,
  input  logic                     dac_upd_i,
  input  logic                     dac_reset_i,
  input  logic                     led_i,
  input  logic                     start_i,
  input  logic [127:0]             name_i,
  input  logic [rp_pkg::ADC_W-1:0] exp_a_i,
  input  logic [rp_pkg::ADC_W-1:0] exp_b_i,
  output logic                     case_done_o,
  output logic                     led_done_o,
  output int                       pass_cnt_o,
  output int                       fail_cnt_o
);

  bit armed   = 1'b0;
  int upd_cnt = 0;
  int edge_n  = 0;   // edges since reset release
  int led_err = 0;

  initial begin
    case_done_o = 1'b0;
    led_done_o  = 1'b0;
    pass_cnt_o  = 0;
    fail_cnt_o  = 0;
  end

  task automatic record(input logic [127:0] nm, input bit ok);
    if (ok) begin
      pass_cnt_o++;
      $display("pass %0s", nm);
    end else begin
      fail_cnt_o++;
      $display("fail %0s", nm);
    end
  endtask

  task automatic compare(input logic [127:0] nm, input string what,
                         input logic [rp_pkg::ADC_W-1:0] exp,
                         input logic [rp_pkg::ADC_W-1:0] act, inout bit ok);
    if (act !== exp) begin
      $display("error %0s %s expected %h actual %h", nm, what, exp, act);
      ok = 1'b0;
    end
  endtask

  //////////////////////////////
  // reset state
  //////////////////////////////

  initial begin
    bit ok;
    ok = 1'b1;
    @(posedge adc_clk iff rst_n_i);  // first edge after release, reset values
    compare("reset_state", "dac_a", 14'h3fff, dac_a_i, ok);
    compare("reset_state", "dac_b", 14'h3fff, dac_b_i, ok);
    compare("reset_state", "dac_upd", 14'h0, 14'(dac_upd_i), ok);
    compare("reset_state", "led", 14'h0, 14'(led_i), ok);
    compare("reset_state", "dac_reset", 14'h1, 14'(dac_reset_i), ok);
    @(posedge adc_clk);
    compare("reset_state", "dac_reset", 14'h0, 14'(dac_reset_i), ok);
    record("reset_state", ok);
  end

  //////////////////////////////
  // cases
  //////////////////////////////

  always @(posedge adc_clk) begin
    bit ok;
    case_done_o <= 1'b0;
    if (start_i) begin
      armed   = 1'b1;
      upd_cnt = 0;
    end else if (armed && dac_upd_i) begin
      upd_cnt++;
      if (upd_cnt == 2) begin  // first one may still be the old sample
        ok    = 1'b1;
        armed = 1'b0;
        compare(name_i, "dac_a", exp_a_i, dac_a_i, ok);
        compare(name_i, "dac_b", exp_b_i, dac_b_i, ok);
        record(name_i, ok);
        case_done_o <= 1'b1;
      end
    end
  end

  // led toggles after every half_period edges
  always @(posedge adc_clk) begin
    if (rst_n_i && !led_done_o) begin
      edge_n++;
      if (led_i !== 1'(((edge_n - 1) / half_period) % 2)) begin
        if (led_err == 0)
          $display("error led expected %b actual %b at cycle %0d",
                   1'(((edge_n - 1) / half_period) % 2), led_i, edge_n);
        led_err++;
      end
      if (edge_n == 8 * half_period) begin
        record("led", led_err == 0);
        led_done_o <= 1'b1;
      end
    end
  end

endmodule

// ==== tb/tb_rp_norm.sv ====
// testbench top for the normalized difference path
// reads the case file, drives raw adc words and waits for the checker

`timescale 1ns/1ps

module tb_rp_norm;

  localparam int LED_HALF       = 8;
  localparam int NAME_W         = 128;  // 16 characters
  localparam int TIMEOUT_MARGIN = 100;

  logic                     adc_clk;
  logic                     rst_n_i;
  logic [rp_pkg::ADC_W-1:0] adc_a_raw;
  logic [rp_pkg::ADC_W-1:0] adc_b_raw;
  logic [rp_pkg::ADC_W-1:0] dac_a;
  logic [rp_pkg::ADC_W-1:0] dac_b;
  logic                     dac_upd;
  logic                     dac_reset;
  logic                     led;

  // checker side
  logic                     start;
  logic [NAME_W-1:0]        name;
  logic [rp_pkg::ADC_W-1:0] exp_a;
  logic [rp_pkg::ADC_W-1:0] exp_b;
  logic                     case_done;
  logic                     led_done;
  int                       pass_cnt;
  int                       fail_cnt;

  // case table
  logic [NAME_W-1:0]        name_q[$];
  logic [rp_pkg::ADC_W-1:0] raw_a_q[$];
  logic [rp_pkg::ADC_W-1:0] raw_b_q[$];
  logic [rp_pkg::ADC_W-1:0] exp_a_q[$];
  logic [rp_pkg::ADC_W-1:0] exp_b_q[$];

  int          cycle_limit = 1000000;  // replaced once the cases are known
  int          cycles = 0;
  bit          cases_ok;

  //////////////////////////////
  // clock and DUT
  //////////////////////////////

  initial adc_clk = 1'b0;
  always #5 adc_clk = ~adc_clk;  // 10 ns

  rp_norm_top #(
    .led_half_period (LED_HALF)
  ) i_rp_norm_top (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .adc_a_raw_i (adc_a_raw),
    .adc_b_raw_i (adc_b_raw),
    .dac_a_o     (dac_a),
    .dac_b_o     (dac_b),
    .dac_upd_o   (dac_upd),
    .dac_reset_o (dac_reset),
    .led_o       (led)
  );

  tb_checker #(
    .half_period (LED_HALF)
  ) i_checker (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .dac_a_i     (dac_a),
    .dac_b_i     (dac_b),
    .dac_upd_i   (dac_upd),
    .dac_reset_i (dac_reset),
    .led_i       (led),
    .start_i     (start),
    .name_i      (name),
    .exp_a_i     (exp_a),
    .exp_b_i     (exp_b),
    .case_done_o (case_done),
    .led_done_o  (led_done),
    .pass_cnt_o  (pass_cnt),
    .fail_cnt_o  (fail_cnt)
  );

  //////////////////////////////
  // case file and stimulus
  //////////////////////////////

  task automatic read_cases(output bit ok);
    int                       fd;
    int                       n;
    string                    line;
    logic [NAME_W-1:0]        nm;
    logic [rp_pkg::ADC_W-1:0] ra;
    logic [rp_pkg::ADC_W-1:0] rb;
    logic [rp_pkg::ADC_W-1:0] ea;
    logic [rp_pkg::ADC_W-1:0] eb;
    ok = 1'b0;
    fd = $fopen("tb/norm_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open the case file tb/norm_cases.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 0 && line.getc(0) != "#") begin
          n = $sscanf(line, "%s %h %h %h %h", nm, ra, rb, ea, eb);
          if (n == 5) begin  // blank or short lines skipped
            name_q.push_back(nm);
            raw_a_q.push_back(ra);
            raw_b_q.push_back(rb);
            exp_a_q.push_back(ea);
            exp_b_q.push_back(eb);
          end
        end
      end
      $fclose(fd);
      ok = (name_q.size() > 0);
      if (!ok)
        $display("no cases were found in tb/norm_cases.txt");
    end
  endtask

  // new raw words, let the pipeline settle, then arm the checker
  task automatic run_case(input int idx);
    @(posedge adc_clk);
    adc_a_raw <= raw_a_q[idx];
    adc_b_raw <= raw_b_q[idx];
    repeat (3) @(posedge adc_clk);  // frontend and sum/diff registers
    start <= 1'b1;
    name  <= name_q[idx];
    exp_a <= exp_a_q[idx];
    exp_b <= exp_b_q[idx];
    @(posedge adc_clk);
    start <= 1'b0;
    do @(posedge adc_clk); while (!case_done);
  endtask

  initial begin
    rst_n_i   = 1'b0;
    adc_a_raw = 14'h1fff;  // code for 0
    adc_b_raw = 14'h1fff;
    start     = 1'b0;
    name      = '0;
    exp_a     = '0;
    exp_b     = '0;
    void'($urandom(32'h82480ece));
    read_cases(cases_ok);
    cycle_limit = name_q.size() * 4 * (rp_pkg::DIVIDEND_W + 8) + TIMEOUT_MARGIN;
    repeat (3) @(posedge adc_clk);
    rst_n_i <= 1'b1;
    if (cases_ok) begin
      for (int i = 0; i < name_q.size(); i++) begin
        repeat ($urandom % 4) @(posedge adc_clk);  // idle gap
        run_case(i);
      end
    end
    while (!led_done) @(posedge adc_clk);
    $display("%0d tests passed, %0d tests failed, %0d assertion failures",
             pass_cnt, fail_cnt, i_rp_norm_top.i_assertions.fail_n);
    if (cases_ok && fail_cnt == 0 && i_rp_norm_top.i_assertions.fail_n == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // hang guard
  initial begin
    while (cycles < cycle_limit) begin
      @(posedge adc_clk);
      cycles++;
    end
    $display("timeout, the run did not finish within %0d cycles", cycle_limit);
    $display("Something failed");
    $finish;
  end

endmodule

// ==== tb/tb_rp_norm_assertions.sv ====
// handshake and update strobe assertions for the normalized difference top

`timescale 1ns/1ps

module tb_rp_norm_assertions (
  input logic                              adc_clk,
  input logic                              rst_n_i,
  input logic                              req_i,
  input logic                              ack_i,
  input logic [rp_pkg::DIVIDEND_W-1:0]     dividend_i,
  input logic [rp_pkg::SUM_W-1:0]          divisor_i,
  input logic                              dac_upd_i
);

  int fail_n = 0;  // failed assertions so far

  // ack only answers an open request
  ack_needs_req: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    $rose(ack_i) |-> req_i)
    else begin
      fail_n++;
      $error("ack rose without req");
    end

  req_held: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    req_i && !ack_i |=> req_i)
    else begin
      fail_n++;
      $error("req dropped before ack");
    end

  operands_stable: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    req_i && $past(req_i) |-> $stable(dividend_i) && $stable(divisor_i))
    else begin
      fail_n++;
      $error("divider operands changed while req was high");
    end

  upd_one_cycle: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    dac_upd_i |=> !dac_upd_i)
    else begin
      fail_n++;
      $error("dac_upd_o longer than one cycle");
    end

endmodule

bind rp_norm_top tb_rp_norm_assertions i_assertions (
  .adc_clk    (adc_clk),
  .rst_n_i    (rst_n_i),
  .req_i      (div_req),
  .ack_i      (div_ack),
  .dividend_i (div_dividend),
  .divisor_i  (div_divisor),
  .dac_upd_i  (dac_upd_o)
);
